/* hw/i2c_standby_pkg.sv */
// Shared constants and types for the standby I2C target, imported by every RTL module

package i2c_standby_pkg;

  // Fixed target address on the I2C bus
  localparam logic [6:0] TARGET_ADDR = 7'h0c;

  // Width of TTI data words and descriptors
  localparam int TTI_DATA_W = 32;

  // Cycles between a seen SCL fall and an SDA change
  localparam int SCL_HOLD_CYC = 2;

  typedef enum logic [1:0] {
    ACQ_DATA = 2'd0,
    ACQ_STOP = 2'd1
  } acq_kind_e;

  typedef struct packed {
    acq_kind_e  kind;
    logic [7:0] data;
  } acq_entry_t;

  // Byte count sits in the low half of the word
  typedef struct packed {
    logic [14:0] reserved;
    logic        err;
    logic [15:0] byte_count;
  } rx_desc_t;

  typedef struct packed {
    logic [15:0] reserved;
    logic [15:0] byte_count;
  } tx_desc_t;

  typedef enum logic [3:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    WR_BYTE,
    WR_ACK,
    RD_LOAD,
    RD_BYTE,
    RD_ACK,
    IGNORE
  } tgt_state_e;

endpackage

/* hw/i2c_target_fsm.sv */
// Bit-level I2C target: START/STOP detection, address match, ACK, SCL stretching and shifting
`timescale 1ns/1ps

module i2c_target_fsm
  import i2c_standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       enable_i,
  input  logic       scl_i,
  input  logic       sda_i,
  output logic       scl_o,
  output logic       sda_o,
  output logic       acq_valid_o,
  output acq_entry_t acq_entry_o,
  input  logic       acq_ready_i,
  input  logic       tx_byte_valid_i,
  input  logic [7:0] tx_byte_i,
  output logic       tx_byte_ready_o,
  output logic       rd_req_o,
  output logic       rd_end_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_prev_q;
  logic       sda_prev_q;
  logic       scl_s;
  logic       sda_s;
  logic       scl_rise;
  logic       scl_fall;
  logic       start_det;
  logic       stop_det;

  tgt_state_e state_q;
  logic [3:0] bit_cnt_q;
  logic [7:0] shreg_q;
  logic       wr_xfer_q;
  logic       rd_xfer_q;
  logic       stop_pend_q;
  logic       nack_q;
  logic [1:0] hold_cnt_q;
  logic       sda_next_q;
  logic       sda_q;
  logic       scl_q;
  logic       acq_valid_q;
  acq_entry_t acq_entry_q;
  logic       rd_req_q;
  logic       rd_end_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_prev_q <= scl_sync_q[1];
      sda_prev_q <= sda_sync_q[1];
    end
  end

  assign scl_s     = scl_sync_q[1];
  assign sda_s     = sda_sync_q[1];
  assign scl_rise  = scl_s && !scl_prev_q;
  assign scl_fall  = !scl_s && scl_prev_q;
  // SDA moving while SCL stays high
  assign start_det = scl_s && scl_prev_q && sda_prev_q && !sda_s;
  assign stop_det  = scl_s && scl_prev_q && !sda_prev_q && sda_s;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      bit_cnt_q   <= '0;
      shreg_q     <= '0;
      wr_xfer_q   <= 1'b0;
      rd_xfer_q   <= 1'b0;
      stop_pend_q <= 1'b0;
      nack_q      <= 1'b0;
      hold_cnt_q  <= '0;
      sda_next_q  <= 1'b1;
      sda_q       <= 1'b1;
      scl_q       <= 1'b1;
      acq_valid_q <= 1'b0;
      acq_entry_q <= '0;
      rd_req_q    <= 1'b0;
      rd_end_q    <= 1'b0;
    end else begin
      rd_req_q <= 1'b0;
      rd_end_q <= 1'b0;
      // Delayed SDA update after SCL fall
      if (hold_cnt_q != 2'd0) begin
        hold_cnt_q <= hold_cnt_q - 2'd1;
        if (hold_cnt_q == 2'd1) begin
          sda_q <= sda_next_q;
        end
      end
      if (!scl_q && hold_cnt_q == 2'd0 && state_q != RD_LOAD &&
          !(state_q == WR_BYTE && acq_valid_q)) begin
        scl_q <= 1'b1;
      end
      if (acq_valid_q && acq_ready_i) begin
        acq_valid_q <= 1'b0;
      end else if (!acq_valid_q && stop_pend_q) begin
        acq_valid_q <= 1'b1;
        acq_entry_q <= '{kind: ACQ_STOP, data: 8'h00};
        stop_pend_q <= 1'b0;
      end

      if (!enable_i || start_det || stop_det) begin
        state_q    <= (enable_i && start_det) ? ADDR : IDLE;
        bit_cnt_q  <= '0;
        hold_cnt_q <= '0;
        sda_next_q <= 1'b1;
        sda_q      <= 1'b1;
        scl_q      <= 1'b1;
        wr_xfer_q  <= 1'b0;
        rd_xfer_q  <= 1'b0;
        // Close whichever transfer was open
        if (wr_xfer_q) begin
          stop_pend_q <= 1'b1;
        end
        if (rd_xfer_q) begin
          rd_end_q <= 1'b1;
        end
      end else begin
        case (state_q)
          ADDR, WR_BYTE: begin
            if (scl_rise) begin
              shreg_q   <= {shreg_q[6:0], sda_s};
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end else if (scl_fall && bit_cnt_q == 4'd8) begin
              if (state_q == WR_BYTE) begin
                state_q     <= WR_ACK;
                sda_next_q  <= 1'b0;
                hold_cnt_q  <= 2'(SCL_HOLD_CYC);
                acq_valid_q <= 1'b1;
                acq_entry_q <= '{kind: ACQ_DATA, data: shreg_q};
              end else if (shreg_q[7:1] == TARGET_ADDR) begin
                state_q    <= ADDR_ACK;
                sda_next_q <= 1'b0;
                hold_cnt_q <= 2'(SCL_HOLD_CYC);
                if (shreg_q[0]) begin
                  rd_xfer_q <= 1'b1;
                  rd_req_q  <= 1'b1;
                end else begin
                  wr_xfer_q <= 1'b1;
                end
              end else begin
                state_q <= IGNORE;
              end
            end
          end
          ADDR_ACK: begin
            if (scl_fall) begin
              bit_cnt_q <= '0;
              if (rd_xfer_q) begin
                state_q <= RD_LOAD;
                scl_q   <= 1'b0;
              end else begin
                state_q    <= WR_BYTE;
                sda_next_q <= 1'b1;
                hold_cnt_q <= 2'(SCL_HOLD_CYC);
              end
            end
          end
          WR_ACK: begin
            if (scl_fall) begin
              state_q    <= WR_BYTE;
              bit_cnt_q  <= '0;
              sda_next_q <= 1'b1;
              hold_cnt_q <= 2'(SCL_HOLD_CYC);
              // Byte not yet taken by the flow
              if (acq_valid_q && !acq_ready_i) begin
                scl_q <= 1'b0;
              end
            end
          end
          RD_LOAD: begin
            if (tx_byte_valid_i) begin
              state_q    <= RD_BYTE;
              shreg_q    <= tx_byte_i;
              bit_cnt_q  <= '0;
              sda_next_q <= tx_byte_i[7];
              hold_cnt_q <= 2'(SCL_HOLD_CYC);
            end
          end
          RD_BYTE: begin
            if (scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end else if (scl_fall) begin
              hold_cnt_q <= 2'(SCL_HOLD_CYC);
              if (bit_cnt_q == 4'd8) begin
                state_q    <= RD_ACK;
                sda_next_q <= 1'b1;
              end else begin
                sda_next_q <= shreg_q[6];
                shreg_q    <= {shreg_q[6:0], 1'b0};
              end
            end
          end
          RD_ACK: begin
            if (scl_rise) begin
              nack_q <= sda_s;
            end else if (scl_fall) begin
              if (nack_q) begin
                state_q   <= IDLE;
                rd_xfer_q <= 1'b0;
                rd_end_q  <= 1'b1;
              end else begin
                state_q <= RD_LOAD;
                scl_q   <= 1'b0;
              end
            end
          end
          IDLE, IGNORE: begin
            state_q <= state_q;
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  // Open drain, released entirely when disabled
  assign scl_o           = scl_q | !enable_i;
  assign sda_o           = sda_q | !enable_i;
  assign acq_valid_o     = acq_valid_q;
  assign acq_entry_o     = acq_entry_q;
  assign tx_byte_ready_o = enable_i && (state_q == RD_LOAD);
  assign rd_req_o        = rd_req_q;
  assign rd_end_o        = rd_end_q;

endmodule

/* hw/i2c_standby_flow.sv */
// Packs received bytes into TTI RX words and descriptors and unpacks TTI TX words into bytes
`timescale 1ns/1ps

module i2c_standby_flow
  import i2c_standby_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  acq_valid_i,
  input  acq_entry_t            acq_entry_i,
  output logic                  acq_ready_o,
  input  logic                  rd_req_i,
  input  logic                  rd_end_i,
  output logic                  tx_byte_valid_o,
  output logic [7:0]            tx_byte_o,
  input  logic                  tx_byte_ready_i,
  output logic                  rx_data_wvalid_o,
  output logic [TTI_DATA_W-1:0] rx_data_wdata_o,
  input  logic                  rx_data_wready_i,
  output logic                  rx_desc_wvalid_o,
  output rx_desc_t              rx_desc_wdata_o,
  input  logic                  rx_desc_wready_i,
  input  logic                  tx_desc_rvalid_i,
  input  tx_desc_t              tx_desc_rdata_i,
  output logic                  tx_desc_rready_o,
  input  logic                  tx_data_rvalid_i,
  input  logic [TTI_DATA_W-1:0] tx_data_rdata_i,
  output logic                  tx_data_rready_o
);

  logic [TTI_DATA_W-1:0] word_q;
  logic [TTI_DATA_W-1:0] word_next;
  logic [1:0]            byte_idx_q;
  logic [15:0]           byte_cnt_q;
  logic                  cnt_ovf_q;
  logic                  desc_pend_q;
  logic                  acq_fire;

  logic                  rd_active_q;
  logic                  desc_wait_q;
  logic [15:0]           rem_q;
  logic [14:0]           words_left_q;
  logic [TTI_DATA_W-1:0] tx_word_q;
  logic [1:0]            tx_sel_q;
  logic                  need_word;
  logic                  drain;

  // Hold off the target while a queue write is outstanding
  assign acq_ready_o = !rx_data_wvalid_o && !rx_desc_wvalid_o && !desc_pend_q;
  assign acq_fire    = acq_valid_i && acq_ready_o;

  always_comb begin
    word_next = word_q;
    word_next[{byte_idx_q, 3'b000} +: 8] = acq_entry_i.data;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      word_q           <= '0;
      byte_idx_q       <= '0;
      byte_cnt_q       <= '0;
      cnt_ovf_q        <= 1'b0;
      desc_pend_q      <= 1'b0;
      rx_data_wvalid_o <= 1'b0;
      rx_data_wdata_o  <= '0;
      rx_desc_wvalid_o <= 1'b0;
      rx_desc_wdata_o  <= '0;
    end else begin
      if (rx_data_wready_i) begin
        rx_data_wvalid_o <= 1'b0;
      end
      if (rx_desc_wready_i) begin
        rx_desc_wvalid_o <= 1'b0;
      end
      // Descriptor only after the last data word is gone
      if (desc_pend_q && !rx_data_wvalid_o) begin
        rx_desc_wvalid_o <= 1'b1;
        desc_pend_q      <= 1'b0;
      end
      if (acq_fire && acq_entry_i.kind == ACQ_DATA) begin
        byte_idx_q <= byte_idx_q + 2'd1;
        if (byte_cnt_q == 16'hffff) begin
          cnt_ovf_q <= 1'b1;
        end else begin
          byte_cnt_q <= byte_cnt_q + 16'd1;
        end
        if (byte_idx_q == 2'd3) begin
          rx_data_wdata_o  <= word_next;
          rx_data_wvalid_o <= 1'b1;
          word_q           <= '0;
        end else begin
          word_q <= word_next;
        end
      end else if (acq_fire) begin
        if (byte_idx_q != 2'd0) begin
          rx_data_wdata_o  <= word_q;
          rx_data_wvalid_o <= 1'b1;
        end
        rx_desc_wdata_o <= '{reserved: '0, err: cnt_ovf_q, byte_count: byte_cnt_q};
        desc_pend_q     <= 1'b1;
        word_q          <= '0;
        byte_idx_q      <= '0;
        byte_cnt_q      <= '0;
        cnt_ovf_q       <= 1'b0;
      end
    end
  end

  // Words left over from an ended read are drained before the next descriptor
  assign need_word = rd_active_q && !desc_wait_q && !tx_byte_valid_o &&
                     rem_q != 16'd0 && tx_sel_q == 2'd0;
  assign drain     = words_left_q != '0 && (!rd_active_q || desc_wait_q);
  assign tx_data_rready_o = (need_word || drain) && tx_data_rvalid_i;
  assign tx_desc_rready_o = desc_wait_q && words_left_q == '0 && tx_desc_rvalid_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_active_q     <= 1'b0;
      desc_wait_q     <= 1'b0;
      rem_q           <= '0;
      words_left_q    <= '0;
      tx_word_q       <= '0;
      tx_sel_q        <= '0;
      tx_byte_valid_o <= 1'b0;
      tx_byte_o       <= '0;
    end else begin
      if (tx_byte_ready_i) begin
        tx_byte_valid_o <= 1'b0;
      end
      if (tx_desc_rready_o) begin
        rem_q        <= tx_desc_rdata_i.byte_count;
        words_left_q <= 15'((17'(tx_desc_rdata_i.byte_count) + 17'd3) >> 2);
        desc_wait_q  <= 1'b0;
        tx_sel_q     <= '0;
      end
      if (tx_data_rready_o) begin
        words_left_q <= words_left_q - 15'd1;
        tx_word_q    <= tx_data_rdata_i;
      end
      if (rd_active_q && !desc_wait_q && !tx_byte_valid_o) begin
        if (rem_q == 16'd0) begin
          tx_byte_o       <= 8'hff;
          tx_byte_valid_o <= 1'b1;
        end else if (tx_sel_q != 2'd0) begin
          tx_byte_o       <= tx_word_q[{tx_sel_q, 3'b000} +: 8];
          tx_byte_valid_o <= 1'b1;
          tx_sel_q        <= tx_sel_q + 2'd1;
          rem_q           <= rem_q - 16'd1;
        end else if (need_word && tx_data_rvalid_i) begin
          tx_byte_o       <= tx_data_rdata_i[7:0];
          tx_byte_valid_o <= 1'b1;
          tx_sel_q        <= 2'd1;
          rem_q           <= rem_q - 16'd1;
        end
      end
      if (rd_req_i) begin
        rd_active_q     <= 1'b1;
        desc_wait_q     <= 1'b1;
        tx_sel_q        <= '0;
        tx_byte_valid_o <= 1'b0;
      end else if (rd_end_i) begin
        rd_active_q     <= 1'b0;
        tx_sel_q        <= '0;
        tx_byte_valid_o <= 1'b0;
      end
    end
  end

endmodule

/* hw/i2c_standby_top.sv */
// Standby I2C target top level, connecting the bus pins and the TTI queues
`timescale 1ns/1ps

module i2c_standby_top
  import i2c_standby_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  standby_en_i,

  input  logic                  scl_i,
  input  logic                  sda_i,
  output logic                  scl_o,
  output logic                  sda_o,

  // TTI RX data
  output logic                  rx_data_wvalid_o,
  output logic [TTI_DATA_W-1:0] rx_data_wdata_o,
  input  logic                  rx_data_wready_i,
  // TTI RX descriptor
  output logic                  rx_desc_wvalid_o,
  output rx_desc_t              rx_desc_wdata_o,
  input  logic                  rx_desc_wready_i,
  // TTI TX descriptor
  input  logic                  tx_desc_rvalid_i,
  input  tx_desc_t              tx_desc_rdata_i,
  output logic                  tx_desc_rready_o,
  // TTI TX data
  input  logic                  tx_data_rvalid_i,
  input  logic [TTI_DATA_W-1:0] tx_data_rdata_i,
  output logic                  tx_data_rready_o
);

  logic       acq_valid;
  acq_entry_t acq_entry;
  logic       acq_ready;
  logic       tx_byte_valid;
  logic [7:0] tx_byte;
  logic       tx_byte_ready;
  logic       rd_req;
  logic       rd_end;

  i2c_target_fsm u_target (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .enable_i        (standby_en_i),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .scl_o           (scl_o),
    .sda_o           (sda_o),
    .acq_valid_o     (acq_valid),
    .acq_entry_o     (acq_entry),
    .acq_ready_i     (acq_ready),
    .tx_byte_valid_i (tx_byte_valid),
    .tx_byte_i       (tx_byte),
    .tx_byte_ready_o (tx_byte_ready),
    .rd_req_o        (rd_req),
    .rd_end_o        (rd_end)
  );

  i2c_standby_flow u_flow (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .acq_valid_i      (acq_valid),
    .acq_entry_i      (acq_entry),
    .acq_ready_o      (acq_ready),
    .rd_req_i         (rd_req),
    .rd_end_i         (rd_end),
    .tx_byte_valid_o  (tx_byte_valid),
    .tx_byte_o        (tx_byte),
    .tx_byte_ready_i  (tx_byte_ready),
    .rx_data_wvalid_o (rx_data_wvalid_o),
    .rx_data_wdata_o  (rx_data_wdata_o),
    .rx_data_wready_i (rx_data_wready_i),
    .rx_desc_wvalid_o (rx_desc_wvalid_o),
    .rx_desc_wdata_o  (rx_desc_wdata_o),
    .rx_desc_wready_i (rx_desc_wready_i),
    .tx_desc_rvalid_i (tx_desc_rvalid_i),
    .tx_desc_rdata_i  (tx_desc_rdata_i),
    .tx_desc_rready_o (tx_desc_rready_o),
    .tx_data_rvalid_i (tx_data_rvalid_i),
    .tx_data_rdata_i  (tx_data_rdata_i),
    .tx_data_rready_o (tx_data_rready_o)
  );

endmodule

/* dv/i2c_standby_checker.sv */
// Concurrent assertions on the standby target ports, bound into the top level
`timescale 1ns/1ps

module i2c_standby_checker (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        standby_en_i,
  input logic        scl_drv_i,
  input logic        sda_drv_i,
  input logic        rx_data_valid_i,
  input logic [31:0] rx_data_word_i,
  input logic        rx_data_ready_i,
  input logic        rx_desc_valid_i,
  input logic [31:0] rx_desc_word_i,
  input logic        rx_desc_ready_i,
  input logic        tx_desc_valid_i,
  input logic        tx_desc_take_i
);

  int unsigned fail_cnt = 0;

  rx_data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_data_valid_i && !rx_data_ready_i |=> rx_data_valid_i && $stable(rx_data_word_i))
    else begin
      $error("RX data word dropped or changed before wready");
      fail_cnt++;
    end

  rx_desc_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_desc_valid_i && !rx_desc_ready_i |=> rx_desc_valid_i && $stable(rx_desc_word_i))
    else begin
      $error("RX descriptor dropped or changed before wready");
      fail_cnt++;
    end

  // Bus fully released outside standby
  bus_released: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !standby_en_i |-> scl_drv_i && sda_drv_i)
    else begin
      $error("Bus driven low while standby is disabled");
      fail_cnt++;
    end

  desc_take_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_desc_take_i |-> tx_desc_valid_i)
    else begin
      $error("TX descriptor rready high without rvalid");
      fail_cnt++;
    end

endmodule

bind i2c_standby_top i2c_standby_checker u_checker (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .standby_en_i    (standby_en_i),
  .scl_drv_i       (scl_o),
  .sda_drv_i       (sda_o),
  .rx_data_valid_i (rx_data_wvalid_o),
  .rx_data_word_i  (rx_data_wdata_o),
  .rx_data_ready_i (rx_data_wready_i),
  .rx_desc_valid_i (rx_desc_wvalid_o),
  .rx_desc_word_i  (rx_desc_wdata_o),
  .rx_desc_ready_i (rx_desc_wready_i),
  .tx_desc_valid_i (tx_desc_rvalid_i),
  .tx_desc_take_i  (tx_desc_rready_o)
);

/* dv/i2c_host_tasks.svh */
// I2C host bit tasks, included into the testbench module body
`ifndef I2C_HOST_TASKS_SVH
`define I2C_HOST_TASKS_SVH

  // Ends just past a rising edge, ready to drive
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #DRV_DLY;
  endtask

  // Honors clock stretching by the DUT
  task automatic wait_scl_high();
    int cnt;
    cnt = 0;
    do begin
      wait_cycles(1);
      cnt++;
    end while (!scl_bus && cnt < SCL_TIMEOUT);
    if (!scl_bus) begin
      abort_run("SCL stayed low, clock stretching never ended");
    end
  endtask

  task automatic send_start();
    host_sda = 1'b0;
    wait_cycles(HALF);
    host_scl = 1'b0;
  endtask

  task automatic send_stop();
    wait_cycles(2);
    host_sda = 1'b0;
    wait_cycles(HALF - 2);
    host_scl = 1'b1;
    wait_scl_high();
    wait_cycles(HALF);
    host_sda = 1'b1;
    wait_cycles(HALF);
  endtask

  // One SCL period, SDA moves only while SCL is low
  task automatic clock_bit(input logic b, output logic r);
    wait_cycles(2);
    host_sda = b;
    wait_cycles(HALF - 2);
    host_scl = 1'b1;
    wait_scl_high();
    wait_cycles(HALF);
    r = sda_bus;
    host_scl = 1'b0;
  endtask

  task automatic write_byte(input logic [7:0] data, output logic ack);
    logic r;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(data[i], r);
    end
    clock_bit(1'b1, r);
    ack = !r;
  endtask

  task automatic read_byte(input logic nack, output logic [7:0] data);
    logic r;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(1'b1, r);
      data[i] = r;
    end
    clock_bit(nack, r);
  endtask

`endif

/* dv/i2c_standby_tb.sv */
// Testbench for the standby I2C target: random host transfers against TTI queue models
`timescale 1ns/1ps

module i2c_standby_tb;

  localparam logic [6:0]  TGT_ADDR     = 7'h0c;
  localparam logic [31:0] SEED         = 32'h79f13a11;
  localparam int          HALF         = 8;
  localparam int          DRV_DLY      = 1;
  localparam int          SCL_TIMEOUT  = 4000;
  localparam int          XFER_TIMEOUT = 4000;
  localparam int          SETTLE_CYC   = 40;

  logic        clk_i;
  logic        rst_n_i;
  logic        standby_en_i;
  logic        host_scl;
  logic        host_sda;
  logic        scl_o;
  logic        sda_o;
  logic        scl_bus;
  logic        sda_bus;
  logic        rx_data_wvalid_o;
  logic [31:0] rx_data_wdata_o;
  logic        rx_data_wready_i;
  logic        rx_desc_wvalid_o;
  logic [31:0] rx_desc_wdata_o;
  logic        rx_desc_wready_i;
  logic        tx_desc_rvalid_i;
  logic [31:0] tx_desc_rdata_i;
  logic        tx_desc_rready_o;
  logic        tx_data_rvalid_i;
  logic [31:0] tx_data_rdata_i;
  logic        tx_data_rready_o;

  logic [31:0] rx_data_got [$];
  logic [31:0] rx_desc_got [$];
  logic [31:0] tx_desc_q [$];
  logic [31:0] tx_data_q [$];
  logic        desc_take;
  logic        data_take;
  logic        bp_mode;
  int unsigned activity;
  string       test_name;
  int unsigned test_errs;
  int unsigned err_total;
  int unsigned tests_run;
  int unsigned tests_failed;

  // Wired AND of host and DUT drivers
  assign scl_bus = host_scl & scl_o;
  assign sda_bus = host_sda & sda_o;

  i2c_standby_top dut_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .standby_en_i     (standby_en_i),
    .scl_i            (scl_bus),
    .sda_i            (sda_bus),
    .scl_o            (scl_o),
    .sda_o            (sda_o),
    .rx_data_wvalid_o (rx_data_wvalid_o),
    .rx_data_wdata_o  (rx_data_wdata_o),
    .rx_data_wready_i (rx_data_wready_i),
    .rx_desc_wvalid_o (rx_desc_wvalid_o),
    .rx_desc_wdata_o  (rx_desc_wdata_o),
    .rx_desc_wready_i (rx_desc_wready_i),
    .tx_desc_rvalid_i (tx_desc_rvalid_i),
    .tx_desc_rdata_i  (tx_desc_rdata_i),
    .tx_desc_rready_o (tx_desc_rready_o),
    .tx_data_rvalid_i (tx_data_rvalid_i),
    .tx_data_rdata_i  (tx_data_rdata_i),
    .tx_data_rready_o (tx_data_rready_o)
  );

  `include "i2c_host_tasks.svh"

  always #5 clk_i = ~clk_i;

  // RX queue side, wready random under back-pressure
  always @(posedge clk_i) begin
    #DRV_DLY;
    if (bp_mode) begin
      rx_data_wready_i = ($urandom % 4) == 0;
      rx_desc_wready_i = ($urandom % 4) == 0;
    end else begin
      rx_data_wready_i = 1'b1;
      rx_desc_wready_i = 1'b1;
    end
  end

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (rx_data_wvalid_o && rx_data_wready_i) begin
        rx_data_got.push_back(rx_data_wdata_o);
      end
      if (rx_desc_wvalid_o && rx_desc_wready_i) begin
        rx_desc_got.push_back(rx_desc_wdata_o);
      end
      if (rx_data_wvalid_o || rx_desc_wvalid_o || tx_desc_rready_o || tx_data_rready_o) begin
        activity++;
      end
    end
  end

  // TX queues, front entry presented while not empty
  always @(posedge clk_i) begin
    desc_take = tx_desc_rvalid_i && tx_desc_rready_o;
    data_take = tx_data_rvalid_i && tx_data_rready_o;
    #DRV_DLY;
    if (desc_take) begin
      void'(tx_desc_q.pop_front());
    end
    if (data_take) begin
      void'(tx_data_q.pop_front());
    end
    tx_desc_rvalid_i = tx_desc_q.size() != 0;
    tx_desc_rdata_i  = (tx_desc_q.size() != 0) ? tx_desc_q[0] : '0;
    tx_data_rvalid_i = tx_data_q.size() != 0;
    tx_data_rdata_i  = (tx_data_q.size() != 0) ? tx_data_q[0] : '0;
  end

  task automatic abort_run(input string why);
    $display("Error in test %s: %s", test_name, why);
    $display("Verification failed");
    $finish;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
    test_errs++;
  endtask

  task automatic report_error(input string what);
    $display("Error in test %s: %s", test_name, what);
    test_errs++;
  endtask

  task automatic open_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic close_test();
    tests_run++;
    err_total += test_errs;
    if (test_errs == 0) begin
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", test_name, test_errs);
    end
  endtask

  task automatic expect_rx_desc();
    int cnt;
    cnt = 0;
    while (rx_desc_got.size() == 0 && cnt < XFER_TIMEOUT) begin
      wait_cycles(1);
      cnt++;
    end
    if (rx_desc_got.size() == 0) begin
      abort_run("no RX descriptor after the write transfer");
    end
  endtask

  task automatic expect_tx_drained();
    int cnt;
    cnt = 0;
    while ((tx_desc_q.size() != 0 || tx_data_q.size() != 0) && cnt < XFER_TIMEOUT) begin
      wait_cycles(1);
      cnt++;
    end
    if (tx_desc_q.size() != 0 || tx_data_q.size() != 0) begin
      abort_run("TX queues not drained after the read transfer");
    end
  endtask

  task automatic run_write(input string name, input logic [6:0] addr, input int n,
                           input logic bp);
    logic [7:0]  data_q [$];
    logic [31:0] exp_words [$];
    logic [31:0] word;
    logic        ack;
    logic        match;
    int unsigned act0;
    open_test(name);
    bp_mode = bp;
    act0 = activity;
    match = standby_en_i && addr == TGT_ADDR;
    for (int i = 0; i < n; i++) begin
      data_q.push_back(8'($urandom));
    end
    // Little-endian packing, last word zero filled
    word = '0;
    for (int i = 0; i < n; i++) begin
      word[(i % 4) * 8 +: 8] = data_q[i];
      if (i % 4 == 3 || i == n - 1) begin
        exp_words.push_back(word);
        word = '0;
      end
    end
    send_start();
    write_byte({addr, 1'b0}, ack);
    if (ack !== match) begin
      report_mismatch("address ack", 32'(match), 32'(ack));
    end
    if (ack) begin
      for (int i = 0; i < n; i++) begin
        write_byte(data_q[i], ack);
        if (ack !== 1'b1) begin
          report_mismatch($sformatf("data ack %0d", i), 32'd1, 32'(ack));
        end
      end
    end
    send_stop();
    if (match) begin
      expect_rx_desc();
      if (rx_data_got.size() != exp_words.size()) begin
        report_mismatch("rx word count", exp_words.size(), rx_data_got.size());
      end else begin
        foreach (exp_words[i]) begin
          if (rx_data_got[i] !== exp_words[i]) begin
            report_mismatch($sformatf("rx word %0d", i), exp_words[i], rx_data_got[i]);
          end
        end
      end
      if (rx_desc_got[0] !== 32'(n)) begin
        report_mismatch("rx descriptor", 32'(n), rx_desc_got[0]);
      end
    end else begin
      wait_cycles(SETTLE_CYC);
      if (activity != act0) begin
        report_error("TTI queue activity after a NACKed address");
      end
    end
    rx_data_got.delete();
    rx_desc_got.delete();
    bp_mode = 1'b0;
    close_test();
  endtask

  task automatic run_read(input string name, input int n, input int n_read);
    logic [7:0]  data_q [$];
    logic [31:0] word;
    logic [7:0]  got;
    logic [7:0]  exp;
    logic        ack;
    open_test(name);
    for (int i = 0; i < n; i++) begin
      data_q.push_back(8'($urandom));
    end
    word = '0;
    for (int i = 0; i < n; i++) begin
      word[(i % 4) * 8 +: 8] = data_q[i];
      if (i % 4 == 3 || i == n - 1) begin
        tx_data_q.push_back(word);
        word = '0;
      end
    end
    tx_desc_q.push_back(32'(n));
    wait_cycles(1);
    send_start();
    write_byte({TGT_ADDR, 1'b1}, ack);
    if (ack !== 1'b1) begin
      report_mismatch("address ack", 32'd1, 32'(ack));
    end else begin
      for (int i = 0; i < n_read; i++) begin
        read_byte(i == n_read - 1, got);
        // Past the descriptor count the target pads with ff
        exp = (i < n) ? data_q[i] : 8'hff;
        if (got !== exp) begin
          report_mismatch($sformatf("read byte %0d", i), 32'(exp), 32'(got));
        end
      end
    end
    send_stop();
    if (ack === 1'b1) begin
      expect_tx_drained();
    end else begin
      tx_desc_q.delete();
      tx_data_q.delete();
    end
    close_test();
  endtask

  initial begin
    int n;
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    standby_en_i     = 1'b1;
    host_scl         = 1'b1;
    host_sda         = 1'b1;
    rx_data_wready_i = 1'b0;
    rx_desc_wready_i = 1'b0;
    tx_desc_rvalid_i = 1'b0;
    tx_desc_rdata_i  = '0;
    tx_data_rvalid_i = 1'b0;
    tx_data_rdata_i  = '0;
    bp_mode          = 1'b0;
    activity         = 0;
    err_total        = 0;
    tests_run        = 0;
    tests_failed     = 0;
    test_name        = "reset";
    void'($urandom(SEED));
    repeat (8) @(posedge clk_i);
    #DRV_DLY;
    rst_n_i = 1'b1;
    wait_cycles(2);

    open_test("reset_outputs");
    if ({scl_o, sda_o} !== 2'b11) begin
      report_mismatch("bus drive", 32'd3, 32'({scl_o, sda_o}));
    end
    if ({rx_data_wvalid_o, rx_desc_wvalid_o, tx_desc_rready_o, tx_data_rready_o} !== 4'd0) begin
      report_error("queue valid or ready high after reset");
    end
    close_test();

    run_write("write_empty", TGT_ADDR, 0, 1'b0);
    for (int k = 0; k < 4; k++) begin
      run_write($sformatf("write_%0d", k), TGT_ADDR, 1 + $urandom % 9, 1'b0);
    end
    run_write("write_wrong_addr", TGT_ADDR ^ 7'(1 + $urandom % 127), 3, 1'b0);
    for (int k = 0; k < 3; k++) begin
      n = 1 + $urandom % 8;
      run_read($sformatf("read_%0d", k), n, n);
    end
    n = 1 + $urandom % 8;
    run_read("read_overrun", n, n + 2);
    n = 1 + $urandom % 8;
    run_read("read_after_overrun", n, n);
    n = 2 + $urandom % 7;
    run_read("read_early_stop", n, 1 + $urandom % (n - 1));
    n = 1 + $urandom % 8;
    run_read("read_after_early_stop", n, n);
    for (int k = 0; k < 3; k++) begin
      run_write($sformatf("write_backpressure_%0d", k), TGT_ADDR, 1 + $urandom % 9, 1'b1);
    end

    standby_en_i = 1'b0;
    wait_cycles(2);
    run_write("write_standby_off", TGT_ADDR, 2, 1'b0);
    standby_en_i = 1'b1;
    wait_cycles(2);

    $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, err_total, dut_i.u_checker.fail_cnt);
    if (tests_failed == 0 && err_total == 0 && dut_i.u_checker.fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+dv
hw/i2c_standby_pkg.sv
hw/i2c_target_fsm.sv
hw/i2c_standby_flow.sv
hw/i2c_standby_top.sv
dv/i2c_standby_checker.sv
dv/i2c_standby_tb.sv

/* Bender.yml */
package:
  name: i2c_standby

sources:
  - target: rtl
    files:
      - hw/i2c_standby_pkg.sv
      - hw/i2c_target_fsm.sv
      - hw/i2c_standby_flow.sv
      - hw/i2c_standby_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - hw/i2c_standby_pkg.sv
      - hw/i2c_target_fsm.sv
      - hw/i2c_standby_flow.sv
      - hw/i2c_standby_top.sv
      - dv/i2c_standby_checker.sv
      - dv/i2c_standby_tb.sv
